//--- logic/renamePkg.sv
package renamePkg;

   // default bundle geometry, the top level picks these up as parameter defaults
   localparam int DispatchWidth = 4;
   localparam int NumLogRegs = 32;
   localparam int NumPhysRegs = 64;

   // index widths derived from the register counts
   localparam int LogRegBits = $clog2(NumLogRegs);
   localparam int PhysRegBits = $clog2(NumPhysRegs);

   // logical register field
   // valid sits in the compare, so an unused field never matches a used one
   typedef struct packed {
      logic valid;
      logic [LogRegBits-1:0] regId;
   } logRegT;

   // physical register index
   typedef logic [PhysRegBits-1:0] physRegT;

   // one decoded instruction as seen by rename
   typedef struct packed {
      logRegT logDest;
      logRegT logSrc1;
      logRegT logSrc2;
   } decodedInstrT;

   // decoded fields carried through, plus the physical names
   typedef struct packed {
      logRegT logDest;
      logRegT logSrc1;
      logRegT logSrc2;
      physRegT phyDest;
      physRegT phySrc1;
      physRegT phySrc2;
   } renamedInstrT;

endpackage

//--- logic/renameLane.sv
`timescale 1ns/10ps

module renameLane
#(
   parameter int LaneId = 0,
   parameter int DispatchWidth = renamePkg::DispatchWidth
)
(
   // destinations of every lane in the bundle
   input renamePkg::logRegT logDest_i [DispatchWidth],
   input renamePkg::logRegT logSrc1_i,
   input renamePkg::logRegT logSrc2_i,

   // next free registers in pop order
   input renamePkg::physRegT freePhys_i [DispatchWidth],
   // new destinations of the bundle, only the lanes below are read
   input renamePkg::physRegT olderPhyDest_i [DispatchWidth],
   input renamePkg::physRegT rmtMap1_i,
   input renamePkg::physRegT rmtMap2_i,

   output renamePkg::physRegT phyDest_o,
   output renamePkg::physRegT phySrc1_o,
   output renamePkg::physRegT phySrc2_o,
   output logic dontWriteRmt_o
);
   import renamePkg::*;

   // wide enough to count the valid destinations below any lane
   localparam int SelBits = (DispatchWidth > 1) ? $clog2(DispatchWidth) : 1;

   logic [SelBits-1:0] olderDestCount;

   // destination select
   // this lane takes the free entry just past those claimed by older lanes
   // ripple count, so higher lanes see the longer path
   always_comb
   begin
      olderDestCount = '0;
      for (int j = 0; j < LaneId; j++)
      begin
         olderDestCount = olderDestCount + SelBits'(logDest_i[j].valid);
      end
      phyDest_o = freePhys_i[olderDestCount];
   end

   // source rename
   // default is the table read, then walk older lanes oldest first
   // a later match overwrites, so the youngest older producer wins
   // younger lanes are never looked at
   always_comb
   begin
      phySrc1_o = rmtMap1_i;
      phySrc2_o = rmtMap2_i;
      for (int j = 0; j < LaneId; j++)
      begin
         if (logSrc1_i == logDest_i[j])
         begin
            phySrc1_o = olderPhyDest_i[j];
         end
         if (logSrc2_i == logDest_i[j])
         begin
            phySrc2_o = olderPhyDest_i[j];
         end
      end
   end

   // table write suppression
   // a younger lane with the same destination owns the final mapping
   always_comb
   begin
      dontWriteRmt_o = 1'b0;
      for (int j = LaneId + 1; j < DispatchWidth; j++)
      begin
         if (logDest_i[LaneId] == logDest_i[j])
         begin
            dontWriteRmt_o = 1'b1;
         end
      end
   end

endmodule

//--- logic/renameMapTable.sv
`timescale 1ns/10ps

module renameMapTable
#(
   parameter int DispatchWidth = renamePkg::DispatchWidth,
   parameter int NumLogRegs = renamePkg::NumLogRegs
)
(
   input logic clk,
   input logic rstN_i,

   // two read ports per lane, one per source
   input logic [renamePkg::LogRegBits-1:0] readIdx1_i [DispatchWidth],
   input logic [renamePkg::LogRegBits-1:0] readIdx2_i [DispatchWidth],
   output renamePkg::physRegT readMap1_o [DispatchWidth],
   output renamePkg::physRegT readMap2_o [DispatchWidth],

   // one write port per lane
   input logic [DispatchWidth-1:0] writeEn_i,
   input logic [renamePkg::LogRegBits-1:0] writeIdx_i [DispatchWidth],
   input renamePkg::physRegT writeMap_i [DispatchWidth]
);
   import renamePkg::*;

   // current speculative mapping of every logical register
   physRegT mapTable [NumLogRegs];

   // reads see the table before this edge's writes
   always_comb
   begin
      for (int k = 0; k < DispatchWidth; k++)
      begin
         readMap1_o[k] = mapTable[readIdx1_i[k]];
         readMap2_o[k] = mapTable[readIdx2_i[k]];
      end
   end

   // reset to identity, logical r lives in physical r
   // enabled ports never share an index, the lanes filter duplicates
   always_ff @(posedge clk or negedge rstN_i)
   begin
      if (!rstN_i)
      begin
         for (int r = 0; r < NumLogRegs; r++)
         begin
            mapTable[r] <= physRegT'(r);
         end
      end
      else
      begin
         for (int k = 0; k < DispatchWidth; k++)
         begin
            if (writeEn_i[k])
            begin
               mapTable[writeIdx_i[k]] <= writeMap_i[k];
            end
         end
      end
   end

endmodule

//--- logic/specFreeList.sv
`timescale 1ns/10ps

module specFreeList
#(
   parameter int DispatchWidth = renamePkg::DispatchWidth,
   parameter int NumLogRegs = renamePkg::NumLogRegs,
   parameter int NumPhysRegs = renamePkg::NumPhysRegs
)
(
   input logic clk,
   input logic rstN_i,

   // pop side, head entries in the order they will be handed out
   input logic [$clog2(DispatchWidth+1)-1:0] popCount_i,
   output renamePkg::physRegT headRegs_o [DispatchWidth],
   output logic [renamePkg::PhysRegBits:0] freeCount_o,

   // push side, commit returns
   input logic [DispatchWidth-1:0] pushValid_i,
   input renamePkg::physRegT pushPhys_i [DispatchWidth]
);
   import renamePkg::*;

   localparam int CountBits = $clog2(DispatchWidth + 1);
   // registers not mapped at reset
   localparam int InitFree = NumPhysRegs - NumLogRegs;

   physRegT freeBuf [NumPhysRegs];
   logic [PhysRegBits-1:0] headPtr;
   logic [PhysRegBits-1:0] tailPtr;
   logic [PhysRegBits:0] freeCount;

   // compacted push slots and number of pushes this cycle
   logic [PhysRegBits-1:0] pushSlot [DispatchWidth];
   logic [CountBits-1:0] pushCount;

   // circular pointer advance, depth need not be a power of two
   function automatic logic [PhysRegBits-1:0] wrapPtr(input logic [PhysRegBits-1:0] base,
                                                      input int unsigned step);
      int unsigned sum;
      sum = base + step;
      if (sum >= NumPhysRegs)
      begin
         sum = sum - NumPhysRegs;
      end
      return PhysRegBits'(sum);
   endfunction

   // head window, entries past the count are stale but never popped
   always_comb
   begin
      for (int k = 0; k < DispatchWidth; k++)
      begin
         headRegs_o[k] = freeBuf[wrapPtr(headPtr, k)];
      end
   end

   // valid pushes are packed in lane order behind the tail
   always_comb
   begin
      int unsigned offset;
      offset = 0;
      for (int k = 0; k < DispatchWidth; k++)
      begin
         pushSlot[k] = wrapPtr(tailPtr, offset);
         offset = offset + pushValid_i[k];
      end
      pushCount = CountBits'(offset);
   end

   assign freeCount_o = freeCount;

   // preload NumLogRegs .. NumPhysRegs-1 ascending from slot 0
   // occupancy never passes InitFree, only popped registers come back
   always_ff @(posedge clk or negedge rstN_i)
   begin
      if (!rstN_i)
      begin
         for (int i = 0; i < NumPhysRegs; i++)
         begin
            freeBuf[i] <= physRegT'(NumLogRegs + i);
         end
         headPtr <= '0;
         tailPtr <= PhysRegBits'(InitFree);
         freeCount <= (PhysRegBits+1)'(InitFree);
      end
      else
      begin
         for (int k = 0; k < DispatchWidth; k++)
         begin
            if (pushValid_i[k])
            begin
               freeBuf[pushSlot[k]] <= pushPhys_i[k];
            end
         end
         headPtr <= wrapPtr(headPtr, popCount_i);
         tailPtr <= wrapPtr(tailPtr, pushCount);
         // pushes and pops can land on the same edge
         freeCount <= freeCount + (PhysRegBits+1)'(pushCount) - (PhysRegBits+1)'(popCount_i);
      end
   end

endmodule

//--- logic/renameStage.sv
`timescale 1ns/10ps

module renameStage
#(
   parameter int DispatchWidth = renamePkg::DispatchWidth,
   parameter int NumLogRegs = renamePkg::NumLogRegs,
   parameter int NumPhysRegs = renamePkg::NumPhysRegs
)
(
   input logic clk,
   input logic rstN_i,

   // decoded bundle in
   input logic bundleValid_i,
   output logic bundleReady_o,
   input renamePkg::decodedInstrT bundle_i [DispatchWidth],

   // renamed bundle out
   output logic renamedValid_o,
   input logic renamedReady_i,
   output renamePkg::renamedInstrT renamed_o [DispatchWidth],

   // freed registers returning at commit
   input logic [DispatchWidth-1:0] commitValid_i,
   input renamePkg::physRegT commitPhys_i [DispatchWidth]
);
   import renamePkg::*;

   localparam int CountBits = $clog2(DispatchWidth + 1);

   logic [CountBits-1:0] destCount;
   logic [CountBits-1:0] popCount;
   logic [PhysRegBits:0] freeCount;
   logic outFree;
   logic accept;

   // per-lane views of the bundle
   logRegT logDest [DispatchWidth];
   logic [LogRegBits-1:0] srcIdx1 [DispatchWidth];
   logic [LogRegBits-1:0] srcIdx2 [DispatchWidth];
   logic [LogRegBits-1:0] destIdx [DispatchWidth];

   // lane results
   physRegT headRegs [DispatchWidth];
   physRegT rmtMap1 [DispatchWidth];
   physRegT rmtMap2 [DispatchWidth];
   physRegT phyDest [DispatchWidth];
   physRegT phySrc1 [DispatchWidth];
   physRegT phySrc2 [DispatchWidth];
   logic [DispatchWidth-1:0] dontWriteRmt;
   logic [DispatchWidth-1:0] rmtWriteEn;
   renamedInstrT nextRenamed [DispatchWidth];

   // split the bundle and count the registers it needs
   always_comb
   begin
      destCount = '0;
      for (int k = 0; k < DispatchWidth; k++)
      begin
         logDest[k] = bundle_i[k].logDest;
         destIdx[k] = bundle_i[k].logDest.regId;
         srcIdx1[k] = bundle_i[k].logSrc1.regId;
         srcIdx2[k] = bundle_i[k].logSrc2.regId;
         destCount = destCount + CountBits'(bundle_i[k].logDest.valid);
      end
   end

   // room downstream and enough free registers for every destination
   assign outFree = !renamedValid_o || renamedReady_i;
   assign bundleReady_o = outFree && (freeCount >= (PhysRegBits+1)'(destCount));
   assign accept = bundleValid_i && bundleReady_o;
   assign popCount = accept ? destCount : '0;

   for (genvar k = 0; k < DispatchWidth; k++)
   begin : gLane
      renameLane
      #(
         .LaneId(k),
         .DispatchWidth(DispatchWidth)
      )
      lane_i
      (
         .logDest_i(logDest),
         .logSrc1_i(bundle_i[k].logSrc1),
         .logSrc2_i(bundle_i[k].logSrc2),
         .freePhys_i(headRegs),
         .olderPhyDest_i(phyDest),
         .rmtMap1_i(rmtMap1[k]),
         .rmtMap2_i(rmtMap2[k]),
         .phyDest_o(phyDest[k]),
         .phySrc1_o(phySrc1[k]),
         .phySrc2_o(phySrc2[k]),
         .dontWriteRmt_o(dontWriteRmt[k])
      );

      // only the youngest writer of a logical register updates the table
      assign rmtWriteEn[k] = accept && bundle_i[k].logDest.valid && !dontWriteRmt[k];

      always_comb
      begin
         nextRenamed[k].logDest = bundle_i[k].logDest;
         nextRenamed[k].logSrc1 = bundle_i[k].logSrc1;
         nextRenamed[k].logSrc2 = bundle_i[k].logSrc2;
         nextRenamed[k].phyDest = phyDest[k];
         nextRenamed[k].phySrc1 = phySrc1[k];
         nextRenamed[k].phySrc2 = phySrc2[k];
      end
   end

   renameMapTable
   #(
      .DispatchWidth(DispatchWidth),
      .NumLogRegs(NumLogRegs)
   )
   rmt_i
   (
      .clk(clk),
      .rstN_i(rstN_i),
      .readIdx1_i(srcIdx1),
      .readIdx2_i(srcIdx2),
      .readMap1_o(rmtMap1),
      .readMap2_o(rmtMap2),
      .writeEn_i(rmtWriteEn),
      .writeIdx_i(destIdx),
      .writeMap_i(phyDest)
   );

   specFreeList
   #(
      .DispatchWidth(DispatchWidth),
      .NumLogRegs(NumLogRegs),
      .NumPhysRegs(NumPhysRegs)
   )
   freeList_i
   (
      .clk(clk),
      .rstN_i(rstN_i),
      .popCount_i(popCount),
      .headRegs_o(headRegs),
      .freeCount_o(freeCount),
      .pushValid_i(commitValid_i),
      .pushPhys_i(commitPhys_i)
   );

   // output valid, set on accept, cleared once the consumer takes it
   always_ff @(posedge clk or negedge rstN_i)
   begin
      if (!rstN_i)
      begin
         renamedValid_o <= 1'b0;
      end
      else if (accept)
      begin
         renamedValid_o <= 1'b1;
      end
      else if (renamedReady_i)
      begin
         renamedValid_o <= 1'b0;
      end
   end

   // payload holds while stalled, accept only happens when the slot frees up
   always_ff @(posedge clk)
   begin
      if (accept)
      begin
         renamed_o <= nextRenamed;
      end
   end

endmodule

//--- tb/clockGen.sv
`timescale 1ns/10ps

module clockGen
#(
   parameter int PeriodNs = 4
)
(
   output logic clk_o
);

   // free-running clock, starts low so the first edge is a rising one
   initial
   begin
      clk_o = 1'b0;
      forever
      begin
         #(PeriodNs / 2.0) clk_o = ~clk_o;
      end
   end

endmodule

//--- tb/renameTb.sv
`timescale 1ns/10ps

module renameTb;
   import renamePkg::*;

   localparam int ClkPeriod = 4;
   localparam int ResetCycles = 10;
   // a bundle waits at most five edges and returns on the next falling edge
   localparam int BundleCycles = 6;
   localparam int RandomBundles = 40;
   // ten directed wait windows plus the random bundles and the commit cycles
   localparam int TestCycles = (10 + RandomBundles) * BundleCycles + NumPhysRegs;

   logic clk;
   logic rstN;
   logic bundleValid;
   logic bundleReady;
   decodedInstrT bundle [DispatchWidth];
   logic renamedValid;
   logic renamedReady;
   renamedInstrT renamed [DispatchWidth];
   logic [DispatchWidth-1:0] commitValid;
   physRegT commitPhys [DispatchWidth];

   // reference model of the map table and the free list
   physRegT modelMap [NumLogRegs];
   physRegT freeQ [$];
   // registers displaced from the map and handed back through commit
   physRegT retired [$];

   decodedInstrT stim [DispatchWidth];
   renamedInstrT expected [DispatchWidth];
   int mismatchCount;
   int failCount;
   logic [15:0] lfsrState;

   clockGen #(.PeriodNs(ClkPeriod)) clock_i (.clk_o(clk));

   renameStage
   #(
      .DispatchWidth(DispatchWidth),
      .NumLogRegs(NumLogRegs),
      .NumPhysRegs(NumPhysRegs)
   )
   dut_i
   (
      .clk(clk),
      .rstN_i(rstN),
      .bundleValid_i(bundleValid),
      .bundleReady_o(bundleReady),
      .bundle_i(bundle),
      .renamedValid_o(renamedValid),
      .renamedReady_i(renamedReady),
      .renamed_o(renamed),
      .commitValid_i(commitValid),
      .commitPhys_i(commitPhys)
   );

   // 16-bit fibonacci lfsr with taps 16 14 13 11
   function automatic logic lfsrBit();
      logic fb;
      fb = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
      lfsrState = {lfsrState[14:0], fb};
      return fb;
   endfunction

   // one lfsr step per bit taken
   function automatic int randBits(input int n);
      int v;
      v = 0;
      for (int i = 0; i < n; i++)
      begin
         v = (v << 1) | int'(lfsrBit());
      end
      return v;
   endfunction

   task automatic setLane(input int k, input bit dv, input int d, input bit s1v, input int s1,
                          input bit s2v, input int s2);
      stim[k].logDest = '{valid: dv, regId: LogRegBits'(d)};
      stim[k].logSrc1 = '{valid: s1v, regId: LogRegBits'(s1)};
      stim[k].logSrc2 = '{valid: s2v, regId: LogRegBits'(s2)};
   endtask

   function automatic int countDests();
      int n;
      n = 0;
      for (int k = 0; k < DispatchWidth; k++)
      begin
         n = n + int'(stim[k].logDest.valid);
      end
      return n;
   endfunction

   task automatic checkValue(input string field, input int lane, input logic [63:0] got,
                             input logic [63:0] want);
      if (got !== want)
      begin
         mismatchCount++;
         $display("mismatch at %0t: lane %0d %s is %0d, expected %0d",
                  $time, lane, field, got, want);
      end
   endtask

   // predict the current stimulus and advance the model
   task automatic predictRename();
      int used;
      used = 0;
      for (int k = 0; k < DispatchWidth; k++)
      begin
         expected[k].logDest = stim[k].logDest;
         expected[k].logSrc1 = stim[k].logSrc1;
         expected[k].logSrc2 = stim[k].logSrc2;
         expected[k].phyDest = '0;
         if (stim[k].logDest.valid)
         begin
            expected[k].phyDest = freeQ[used];
            used++;
         end
         expected[k].phySrc1 = modelMap[stim[k].logSrc1.regId];
         expected[k].phySrc2 = modelMap[stim[k].logSrc2.regId];
         // walk oldest to youngest so the last matching older lane sticks
         for (int j = 0; j < k; j++)
         begin
            if (stim[j].logDest.valid && stim[j].logDest.regId == stim[k].logSrc1.regId)
            begin
               expected[k].phySrc1 = expected[j].phyDest;
            end
            if (stim[j].logDest.valid && stim[j].logDest.regId == stim[k].logSrc2.regId)
            begin
               expected[k].phySrc2 = expected[j].phyDest;
            end
         end
      end
      // table writes in lane order so the youngest writer lands last
      for (int k = 0; k < DispatchWidth; k++)
      begin
         if (stim[k].logDest.valid)
         begin
            retired.push_back(modelMap[stim[k].logDest.regId]);
            modelMap[stim[k].logDest.regId] = expected[k].phyDest;
         end
      end
      for (int n = 0; n < used; n++)
      begin
         void'(freeQ.pop_front());
      end
   endtask

   task automatic checkRenamed();
      if (!renamedValid)
      begin
         failCount++;
         $display("renamed output not valid one cycle after acceptance, time %0t", $time);
      end
      for (int k = 0; k < DispatchWidth; k++)
      begin
         checkValue("logDest", k, renamed[k].logDest, expected[k].logDest);
         checkValue("logSrc1", k, renamed[k].logSrc1, expected[k].logSrc1);
         checkValue("logSrc2", k, renamed[k].logSrc2, expected[k].logSrc2);
         if (expected[k].logDest.valid)
         begin
            checkValue("phyDest", k, renamed[k].phyDest, expected[k].phyDest);
         end
         if (expected[k].logSrc1.valid)
         begin
            checkValue("phySrc1", k, renamed[k].phySrc1, expected[k].phySrc1);
         end
         if (expected[k].logSrc2.valid)
         begin
            checkValue("phySrc2", k, renamed[k].phySrc2, expected[k].phySrc2);
         end
      end
   endtask

   // called on a falling edge
   task automatic driveBundle();
      bundle = stim;
      bundleValid = 1'b1;
   endtask

   // returns on the falling edge after the transfer or after maxCycles
   task automatic waitTaken(input int maxCycles, output bit taken);
      int waited;
      taken = 1'b0;
      waited = 0;
      while (!taken && waited < maxCycles)
      begin
         @(posedge clk);
         // valid is high so ready before the edge means a transfer
         taken = bundleReady;
         waited++;
      end
      @(negedge clk);
      if (taken)
      begin
         bundleValid = 1'b0;
      end
   endtask

   task automatic acceptAndCheck(input string name, input int maxCycles);
      bit taken;
      waitTaken(maxCycles, taken);
      if (!taken)
      begin
         failCount++;
         $display("bundle '%s' was never accepted, time %0t", name, $time);
         bundleValid = 1'b0;
      end
      else
      begin
         predictRename();
         checkRenamed();
      end
   endtask

   // one commit cycle with lane 1 left idle so the push side has to compact
   task automatic commitFreed();
      commitValid = '0;
      for (int k = 0; k < DispatchWidth; k++)
      begin
         if (k != 1 && retired.size() > 0)
         begin
            commitValid[k] = 1'b1;
            commitPhys[k] = retired.pop_front();
            freeQ.push_back(commitPhys[k]);
         end
      end
      @(posedge clk);
      @(negedge clk);
      commitValid = '0;
   endtask

   // after reset sources map to themselves and destinations count up from 32
   task automatic independentBundle();
      int n;
      setLane(0, 1, 1, 1, 2, 1, 3);
      setLane(1, 0, 0, 1, 4, 1, 5);
      setLane(2, 1, 6, 1, 7, 0, 0);
      setLane(3, 1, 8, 1, 9, 1, 10);
      driveBundle();
      acceptAndCheck("independent", 4);
      n = 0;
      for (int k = 0; k < DispatchWidth; k++)
      begin
         if (stim[k].logSrc1.valid)
         begin
            checkValue("phySrc1 identity", k, renamed[k].phySrc1, stim[k].logSrc1.regId);
         end
         if (stim[k].logSrc2.valid)
         begin
            checkValue("phySrc2 identity", k, renamed[k].phySrc2, stim[k].logSrc2.regId);
         end
         if (stim[k].logDest.valid)
         begin
            checkValue("phyDest order", k, renamed[k].phyDest, NumLogRegs + n);
            n++;
         end
      end
   endtask

   // lanes 0 and 1 both write r5 while lane 2 reads r9 that only lane 3 writes
   task automatic dependentBundle();
      setLane(0, 1, 5, 1, 20, 0, 0);
      setLane(1, 1, 5, 1, 5, 1, 21);
      setLane(2, 1, 7, 1, 5, 1, 9);
      setLane(3, 1, 9, 1, 7, 1, 5);
      driveBundle();
      acceptAndCheck("dependencies", 4);
   endtask

   // the next bundle must see the younger of two writers of r12
   task automatic mapTableUpdate();
      physRegT youngerMap;
      setLane(0, 1, 12, 1, 1, 0, 0);
      setLane(1, 1, 13, 1, 2, 1, 3);
      setLane(2, 1, 12, 1, 12, 0, 0);
      setLane(3, 0, 0, 1, 13, 0, 0);
      driveBundle();
      acceptAndCheck("map writes", 4);
      youngerMap = expected[2].phyDest;
      setLane(0, 0, 0, 1, 12, 1, 13);
      setLane(1, 0, 0, 1, 5, 1, 7);
      setLane(2, 0, 0, 1, 6, 1, 9);
      setLane(3, 0, 0, 1, 20, 1, 12);
      driveBundle();
      acceptAndCheck("map reads", 4);
      checkValue("phySrc1 younger mapping", 0, renamed[0].phySrc1, youngerMap);
   endtask

   // output held while the consumer stalls and the next bundle waits at the input
   task automatic outputStall();
      renamedInstrT held [DispatchWidth];
      bit taken;
      setLane(0, 1, 3, 1, 12, 1, 9);
      setLane(1, 1, 4, 1, 3, 0, 0);
      setLane(2, 0, 0, 1, 4, 1, 5);
      setLane(3, 1, 3, 1, 3, 1, 4);
      driveBundle();
      acceptAndCheck("before stall", 4);
      renamedReady = 1'b0;
      held = renamed;
      setLane(0, 1, 4, 1, 3, 1, 4);
      setLane(1, 1, 14, 1, 4, 1, 7);
      setLane(2, 1, 15, 1, 14, 1, 3);
      setLane(3, 0, 0, 1, 15, 1, 12);
      driveBundle();
      waitTaken(5, taken);
      if (taken)
      begin
         failCount++;
         $display("bundle accepted while the output was stalled, time %0t", $time);
      end
      if (!renamedValid)
      begin
         failCount++;
         $display("renamed output dropped its valid during a stall, time %0t", $time);
      end
      for (int k = 0; k < DispatchWidth; k++)
      begin
         checkValue("held output", k, renamed[k], held[k]);
      end
      renamedReady = 1'b1;
      acceptAndCheck("after stall", 4);
   endtask

   // drain the free list with random bundles and refill it through commit
   task automatic freeListDrain();
      int need;
      int dv;
      int d;
      int s1v;
      int s1;
      int s2v;
      int s2;
      bit taken;
      bit blocked;
      blocked = 1'b0;
      for (int n = 0; n < RandomBundles && !blocked; n++)
      begin
         for (int k = 0; k < DispatchWidth; k++)
         begin
            // destination present three times in four
            dv = randBits(2);
            d = randBits(LogRegBits);
            s1v = randBits(1);
            s1 = randBits(LogRegBits);
            s2v = randBits(1);
            s2 = randBits(LogRegBits);
            setLane(k, dv != 0, d, s1v != 0, s1, s2v != 0, s2);
         end
         need = countDests();
         driveBundle();
         if (freeQ.size() >= need)
         begin
            acceptAndCheck("random", 4);
         end
         else
         begin
            blocked = 1'b1;
            waitTaken(4, taken);
            if (taken)
            begin
               failCount++;
               $display("bundle accepted with too few free registers, time %0t", $time);
            end
            while (freeQ.size() < need && retired.size() > 0)
            begin
               commitFreed();
            end
            acceptAndCheck("after commit", 4);
         end
      end
      if (!blocked)
      begin
         failCount++;
         $display("free list never ran short of registers");
      end
   endtask

   task automatic printCounts();
      $display("error counts: %0d mismatches, %0d other failures", mismatchCount, failCount);
   endtask

   initial
   begin
      #((ResetCycles + TestCycles) * ClkPeriod + 100);
      $display("watchdog expired, tests did not finish within %0d cycles", TestCycles);
      printCounts();
      $display("*** TEST FAILED ***");
      $finish;
   end

   initial
   begin
      lfsrState = 16'd8;
      mismatchCount = 0;
      failCount = 0;
      rstN = 1'b0;
      bundleValid = 1'b0;
      renamedReady = 1'b1;
      commitValid = '0;
      for (int k = 0; k < DispatchWidth; k++)
      begin
         bundle[k] = '0;
         stim[k] = '0;
         commitPhys[k] = '0;
      end
      // same reset contents as the DUT
      for (int r = 0; r < NumLogRegs; r++)
      begin
         modelMap[r] = physRegT'(r);
      end
      for (int p = NumLogRegs; p < NumPhysRegs; p++)
      begin
         freeQ.push_back(physRegT'(p));
      end
      repeat (ResetCycles) @(posedge clk);
      @(negedge clk);
      rstN = 1'b1;
      @(negedge clk);
      independentBundle();
      dependentBundle();
      mapTableUpdate();
      outputStall();
      freeListDrain();
      repeat (2) @(negedge clk);
      printCounts();
      if (mismatchCount == 0 && failCount == 0)
      begin
         $display("*** TEST PASSED ***");
      end
      else
      begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

//--- project.f
logic/renamePkg.sv
logic/renameLane.sv
logic/renameMapTable.sv
logic/specFreeList.sv
logic/renameStage.sv
tb/clockGen.sv
tb/renameTb.sv

//--- Bender.yml
package:
  name: rename_stage

# register-rename stage, top level renameStage
sources:
  # package first, the other files import it
  - files:
      - logic/renamePkg.sv
      - logic/renameLane.sv
      - logic/renameMapTable.sv
      - logic/specFreeList.sv
      - logic/renameStage.sv

  # testbench, top module renameTb
  - target: test
    files:
      - tb/clockGen.sv
      - tb/renameTb.sv
